// ==== Bender.yml ====
package:
  name: move_list

sources:
  # package first, the rest depends on its types
  - logic/move_sort_pkg.sv

  # design
  - files:
      - logic/move_ram.sv
      - logic/move_sort.sv
      - logic/move_list.sv

  # simulation only
  - target: test
    files:
      - test/move_list_chk.sv
      - test/move_list_tb.sv

// ==== all.f ====
logic/move_sort_pkg.sv
logic/move_ram.sv
logic/move_sort.sv
logic/move_list.sv
test/move_list_chk.sv
test/move_list_tb.sv

// ==== logic/move_list.sv ====
`timescale 1ns/1ps

// move list storage with in-place ordering

module move_list
  (
   input logic clk,
   input logic reset,

   input logic sort_start,
   input logic sort_clear,
   input logic white_to_move,

   input logic wr_addr_init,
   input move_sort_pkg::list_write_t list_wr,
   input move_sort_pkg::addr_t rd_addr,
   output move_sort_pkg::move_word_t rd_data,
   output move_sort_pkg::addr_t wr_addr,

   output logic sort_complete
   );

   import move_sort_pkg::*;

   // ram ports as driven by the sorter
   addr_t a_addr;
   addr_t b_addr;
   logic a_wr;
   logic b_wr;
   move_word_t a_wr_data;
   move_word_t b_wr_data;
   move_word_t a_rd_data;
   move_word_t b_rd_data;

   move_sort move_sort_i
     (
      .clk           (clk),
      .reset         (reset),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .wr_addr_init  (wr_addr_init),
      .list_wr       (list_wr),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .wr_addr       (wr_addr),
      .sort_complete (sort_complete),
      .a_addr        (a_addr),
      .a_wr          (a_wr),
      .a_wr_data     (a_wr_data),
      .a_rd_data     (a_rd_data),
      .b_addr        (b_addr),
      .b_wr          (b_wr),
      .b_wr_data     (b_wr_data),
      .b_rd_data     (b_rd_data)
      );

   move_ram move_ram_i
     (
      .clk       (clk),
      .a_addr    (a_addr),
      .a_wr      (a_wr),
      .a_wr_data (a_wr_data),
      .a_rd_data (a_rd_data),
      .b_addr    (b_addr),
      .b_wr      (b_wr),
      .b_wr_data (b_wr_data),
      .b_rd_data (b_rd_data)
      );

endmodule

// ==== logic/move_ram.sv ====
`timescale 1ns/1ps

// true dual-port block ram, read-first on both ports

module move_ram
  (
   input logic clk,

   input move_sort_pkg::addr_t a_addr,
   input logic a_wr,
   input move_sort_pkg::move_word_t a_wr_data,
   output move_sort_pkg::move_word_t a_rd_data,

   input move_sort_pkg::addr_t b_addr,
   input logic b_wr,
   input move_sort_pkg::move_word_t b_wr_data,
   output move_sort_pkg::move_word_t b_rd_data
   );

   import move_sort_pkg::*;

   logic [ram_width-1:0] mem [0:ram_depth-1];

   // both ports in one process, old contents come back on a write
   always_ff @(posedge clk)
   begin
      if (a_wr)
         mem[a_addr] <= a_wr_data.raw;
      if (b_wr)
         mem[b_addr] <= b_wr_data.raw;
      a_rd_data.raw <= mem[a_addr];
      b_rd_data.raw <= mem[b_addr];
   end

endmodule

// ==== logic/move_sort.sv ====
`timescale 1ns/1ps

// in-place bubble sort of the move list
// shares both ram ports with external list write and read

module move_sort
  (
   input logic clk,
   input logic reset,

   input logic sort_start,
   input logic sort_clear,
   input logic white_to_move,

   input logic wr_addr_init,
   input move_sort_pkg::list_write_t list_wr,
   input move_sort_pkg::addr_t rd_addr,
   output move_sort_pkg::move_word_t rd_data,
   output move_sort_pkg::addr_t wr_addr,

   output logic sort_complete,

   // ram port a
   output move_sort_pkg::addr_t a_addr,
   output logic a_wr,
   output move_sort_pkg::move_word_t a_wr_data,
   input move_sort_pkg::move_word_t a_rd_data,

   // ram port b
   output move_sort_pkg::addr_t b_addr,
   output logic b_wr,
   output move_sort_pkg::move_word_t b_wr_data,
   input move_sort_pkg::move_word_t b_rd_data
   );

   import move_sort_pkg::*;

   typedef enum logic [3:0] {
      st_idle,
      st_outer_init,
      st_read_wait_0,
      st_read_wait_1,
      st_compare,
      st_swap,
      st_inner,
      st_outer_test,
      st_done
   } state_t;

   state_t state;

   logic sort_start_z;
   logic start_edge;
   logic ext_access;
   logic ext_wr;

   addr_t sort_a_addr;
   addr_t sort_b_addr;
   logic sort_wr;                       // both ports write together on a swap
   move_word_t sort_a_wr_data;
   move_word_t sort_b_wr_data;

   addr_t n;                            // current pass length
   addr_t newn;                         // address of last swap in this pass
   addr_t last_b_addr;

   move_fields_t fa;
   move_fields_t fb;
   logic swap_needed;

   assign start_edge = sort_start && !sort_start_z;

   // external side owns the ram while idle or done
   assign ext_access = (state == st_idle) || (state == st_done);
   assign ext_wr = list_wr.wr && (state == st_idle); // no list writes once sorting

   assign a_addr = ext_access ? wr_addr : sort_a_addr;
   assign b_addr = ext_access ? rd_addr : sort_b_addr;
   assign a_wr = ext_access ? ext_wr : sort_wr;
   assign b_wr = ext_access ? 1'b0 : sort_wr; // b is read only from outside
   assign a_wr_data = ext_access ? list_wr.data : sort_a_wr_data;
   assign b_wr_data = sort_b_wr_data;

   assign rd_data = b_rd_data;

   assign last_b_addr = n - addr_t'(1);

   assign fa = a_rd_data.fields;
   assign fb = b_rd_data.fields;

   // true when b has to move ahead of a
   always_comb
   begin
      if (fa.pv != fb.pv)
         swap_needed = fb.pv;           // pv first
      else if (fa.capture != fb.capture)
         swap_needed = fb.capture;      // then captures
      else if (white_to_move)
         swap_needed = fa.eval < fb.eval; // best eval first for white
      else
         swap_needed = fa.eval > fb.eval;
   end

   // write counter doubles as the list length
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_addr <= '0;
         sort_start_z <= 1'b0;
      end
      else
      begin
         sort_start_z <= sort_start;
         if (wr_addr_init)
            wr_addr <= '0;
         else if (ext_wr)
            wr_addr <= wr_addr + addr_t'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         sort_complete <= 1'b0;
         sort_wr <= 1'b0;
      end
      else
      begin
         sort_wr <= 1'b0;
         case (state)
            st_idle:
            begin
               n <= wr_addr;
               if (start_edge)
               begin
                  if (wr_addr <= addr_t'(1))
                     state <= st_done; // nothing to order
                  else
                     state <= st_outer_init;
               end
            end
            st_outer_init:
            begin
               newn <= '0;
               sort_a_addr <= '0;
               sort_b_addr <= addr_t'(1);
               state <= st_read_wait_0;
            end
            st_read_wait_0:
               state <= st_read_wait_1; // addresses into the ram
            st_read_wait_1:
               state <= st_compare;     // pair now on the read ports
            st_compare:
            begin
               if (swap_needed)
                  state <= st_swap;
               else
                  state <= st_inner;
            end
            st_swap:
            begin
               // cross the read words back into the same two slots
               sort_wr <= 1'b1;
               sort_a_wr_data <= b_rd_data;
               sort_b_wr_data <= a_rd_data;
               newn <= sort_b_addr;
               state <= st_inner;
            end
            st_inner:
            begin
               sort_a_addr <= sort_a_addr + addr_t'(1);
               sort_b_addr <= sort_b_addr + addr_t'(1);
               if (sort_b_addr == last_b_addr)
                  state <= st_outer_test;
               else
                  state <= st_read_wait_0;
            end
            st_outer_test:
            begin
               // everything past the last swap is already in place
               n <= newn;
               if (newn > addr_t'(1))
                  state <= st_outer_init;
               else
                  state <= st_done;
            end
            st_done:
            begin
               sort_complete <= 1'b1;
               if (sort_clear)
               begin
                  sort_complete <= 1'b0;
                  state <= st_idle;
               end
            end
            default:
               state <= st_idle;
         endcase
      end
   end

endmodule

// ==== logic/move_sort_pkg.sv ====
package move_sort_pkg;

   // list sizing
   localparam int max_positions_log2 = 6;
   localparam int ram_depth = 1 << max_positions_log2;

   // entry layout
   localparam int sq_width = 6;
   localparam int eval_width = 16;
   localparam int ram_width = 32;

   typedef logic [max_positions_log2-1:0] addr_t;

   // one candidate move as the generator packs it
   typedef struct packed {
      logic [sq_width-1:0] from_sq;
      logic [sq_width-1:0] to_sq;
      logic pv;                         // principal variation move
      logic capture;
      logic check;
      logic promote;
      logic signed [eval_width-1:0] eval; // position eval after the move
   } move_fields_t;

   // ram holds raw words, sorter looks at the fields
   typedef union packed {
      logic [ram_width-1:0] raw;
      move_fields_t fields;
   } move_word_t;

   // external list write, strobe plus entry
   typedef struct packed {
      logic wr;
      move_word_t data;
   } list_write_t;

endpackage

// ==== test/move_list_chk.sv ====
`timescale 1ns/1ps

// assertions on the sorter, bound into every move_sort

module move_list_chk
  (
   input logic clk,
   input logic reset,
   input logic start_edge,
   input logic ext_access,
   input logic wr_addr_init,
   input move_sort_pkg::addr_t wr_addr,
   input logic sort_complete,
   input logic a_wr,
   input logic b_wr,
   input move_sort_pkg::addr_t a_addr,
   input move_sort_pkg::addr_t b_addr
   );

   logic armed;                         // start edge seen, completion still owed

   always_ff @(posedge clk)
   begin
      if (reset)
         armed <= 1'b0;
      else if (start_edge)
         armed <= 1'b1;
      else if (sort_complete)
         armed <= 1'b0;
   end

   complete_after_start: assert property (@(posedge clk) disable iff (reset)
      $rose(sort_complete) |-> armed)
      else $error("sort_complete rose without a preceding start edge");

   // list length must not move under a running sort
   counter_holds: assert property (@(posedge clk) disable iff (reset)
      (!ext_access && !wr_addr_init) |=> $stable(wr_addr))
      else $error("write counter changed while sorting");

   single_writer: assert property (@(posedge clk) disable iff (reset)
      !(a_wr && b_wr && (a_addr == b_addr)))
      else $error("both ram ports write the same address");

endmodule

bind move_sort move_list_chk move_list_chk_i
  (
   .clk           (clk),
   .reset         (reset),
   .start_edge    (start_edge),
   .ext_access    (ext_access),
   .wr_addr_init  (wr_addr_init),
   .wr_addr       (wr_addr),
   .sort_complete (sort_complete),
   .a_wr          (a_wr),
   .b_wr          (b_wr),
   .a_addr        (a_addr),
   .b_addr        (b_addr)
   );

// ==== test/move_list_tb.sv ====
`timescale 1ns/1ps

module move_list_tb;

   import move_sort_pkg::*;

   logic clk;
   logic reset;
   logic sort_start;
   logic sort_clear;
   logic white_to_move;
   logic wr_addr_init;
   list_write_t list_wr;
   addr_t rd_addr;
   move_word_t rd_data;
   addr_t wr_addr;
   logic sort_complete;

   logic [31:0] rng_state;
   move_word_t written [0:ram_depth-1];  // list in write order
   move_word_t expected [0:ram_depth-1]; // reference order after the sort
   int list_len;

   move_list dut_i
     (
      .clk           (clk),
      .reset         (reset),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .wr_addr_init  (wr_addr_init),
      .list_wr       (list_wr),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .wr_addr       (wr_addr),
      .sort_complete (sort_complete)
      );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic advance_cycle();
      @(posedge clk);
      #1;                               // drive and sample just after the edge
   endtask

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_word(input string name, input move_word_t got, input move_word_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                  $time, name, got.raw, exp.raw));
   endtask

   task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                  $time, name, got, exp));
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
   endtask

   // mixed entries get pv, captures and a narrow eval range with many ties
   function automatic move_word_t random_move(input bit mixed);
      move_word_t w;
      logic [31:0] r;
      w.raw = next_random();
      r = next_random();
      if (mixed)
      begin
         w.fields.pv = (r[2:0] == 3'd0);
         w.fields.capture = (r[4:3] == 2'd0);
         w.fields.eval = eval_width'(r[10:8]) - eval_width'(4);
      end
      else
      begin
         w.fields.pv = 1'b0;
         w.fields.capture = 1'b0;
      end
      return w;
   endfunction

   // higher key goes first, eval flipped when black is to move
   function automatic int sort_key(input move_word_t w, input logic wtm);
      int ev;
      ev = int'(w.fields.eval);
      if (!wtm)
         ev = -ev;
      return (int'(w.fields.pv) << 18) + (int'(w.fields.capture) << 17) + ev + 32768;
   endfunction

   // stable insertion sort on the key
   task automatic build_expected(input logic wtm);
      int i;
      int j;
      move_word_t w;
      for (i = 0; i < list_len; i++)
      begin
         w = written[i];
         j = i;
         while (j > 0 && sort_key(expected[j-1], wtm) < sort_key(w, wtm))
         begin
            expected[j] = expected[j-1];
            j--;
         end
         expected[j] = w;
      end
   endtask

   task automatic load_list(input int count, input bit mixed);
      int i;
      move_word_t w;
      wr_addr_init = 1'b1;
      advance_cycle();
      wr_addr_init = 1'b0;
      for (i = 0; i < count; i++)
      begin
         w = random_move(mixed);
         written[i] = w;
         list_wr.wr = 1'b1;
         list_wr.data = w;
         advance_cycle();
      end
      list_wr.wr = 1'b0;
      list_len = count;
      compare_addr("wr_addr", wr_addr, addr_t'(count));
   endtask

   task automatic check_list(input string what, input bit sorted);
      int i;
      for (i = 0; i < list_len; i++)
      begin
         rd_addr = addr_t'(i);
         advance_cycle();               // one cycle read latency
         compare_word($sformatf("%s rd_data[%0d]", what, i), rd_data,
                      sorted ? expected[i] : written[i]);
      end
   endtask

   // noisy keeps list writes going while the sort runs
   task automatic run_sort(input logic wtm, input bit noisy, output int cycles);
      white_to_move = wtm;
      sort_start = 1'b1;
      advance_cycle();
      sort_start = 1'b0;
      list_wr.wr = noisy;
      cycles = 1;                       // the start cycle counts
      while (sort_complete !== 1'b1)
      begin
         if (cycles >= ram_depth * ram_depth * 8)
            report_failure("sort_complete did not rise before the timeout");
         if (noisy)
            list_wr.data = random_move(1'b0);
         advance_cycle();
         cycles++;
      end
      list_wr.wr = 1'b0;
   endtask

   task automatic clear_sort();
      compare_bit("sort_complete", sort_complete, 1'b1); // level held through readback
      sort_clear = 1'b1;
      advance_cycle();
      sort_clear = 1'b0;
      compare_bit("sort_complete", sort_complete, 1'b0);
   endtask

   task automatic sort_and_check(input int count, input bit mixed, input logic wtm,
                                 input bit noisy, input string what, output int cycles);
      load_list(count, mixed);
      build_expected(wtm);
      run_sort(wtm, noisy, cycles);
      compare_addr("wr_addr", wr_addr, addr_t'(count));
      check_list(what, 1'b1);          // read back while still done
      clear_sort();
   endtask

   task automatic test_readback();
      load_list(20, 1'b1);
      check_list("unsorted", 1'b0);
   endtask

   task automatic test_white_plain();
      int cycles;
      sort_and_check(30, 1'b0, 1'b1, 1'b0, "white plain", cycles);
   endtask

   task automatic test_black_plain();
      int cycles;
      sort_and_check(30, 1'b0, 1'b0, 1'b0, "black plain", cycles);
   endtask

   task automatic test_mixed_key();
      int cycles;
      sort_and_check(45, 1'b1, 1'b1, 1'b0, "mixed white", cycles);
      sort_and_check(45, 1'b1, 1'b0, 1'b0, "mixed black", cycles);
   endtask

   task automatic test_short_lists();
      int cycles;
      sort_and_check(0, 1'b1, 1'b1, 1'b0, "empty list", cycles);
      if (cycles != 2)
         report_failure("empty list did not complete two cycles after the start");
      sort_and_check(1, 1'b1, 1'b0, 1'b0, "single entry", cycles);
      if (cycles != 2)
         report_failure("single entry list did not complete two cycles after the start");
   endtask

   task automatic test_back_to_back();
      int cycles;
      sort_and_check(ram_depth - 1, 1'b1, 1'b1, 1'b1, "full list", cycles);
      sort_and_check(2, 1'b0, 1'b0, 1'b1, "pair", cycles);
      sort_and_check(17, 1'b1, 1'b0, 1'b1, "list of 17", cycles);
      sort_and_check(40, 1'b0, 1'b1, 1'b1, "list of 40", cycles);
   endtask

   initial
   begin
      rng_state = 32'hd5dde551;
      reset = 1'b1;
      sort_start = 1'b0;
      sort_clear = 1'b0;
      white_to_move = 1'b1;
      wr_addr_init = 1'b0;
      list_wr = '0;
      rd_addr = '0;
      list_len = 0;
      repeat (2) advance_cycle();
      reset = 1'b0;
      compare_bit("sort_complete", sort_complete, 1'b0);
      compare_addr("wr_addr", wr_addr, '0);

      test_readback();
      test_white_plain();
      test_black_plain();
      test_mixed_key();
      test_short_lists();
      test_back_to_back();

      $display("Everything OK");
      $finish;
   end

endmodule
